// ==== include/ntm_convolution_cfg.svh ====
// Convolution engine configuration: default data, index and modulus width
`ifndef NTM_CONVOLUTION_CFG_SVH
`define NTM_CONVOLUTION_CFG_SVH

//////////////////////////////
// Widths
//////////////////////////////

// Width of operands, modulus, row and pair counts
// Anything from 4 bits upward works
`define NTM_DATA_SIZE 32

// Multiplier latency is NTM_DATA_SIZE+1 cycles from START to READY
// Accumulator adds 2 cycles on top of that

`endif

// ==== logic/ntm_convolution_pkg.sv ====
// Convolution engine package: FSM state types of sequencer, accumulator and multiplier
`default_nettype none

package ntm_convolution_pkg;

  //////////////////////////////
  // Row sequencer
  //////////////////////////////

  // Idle, first pair of a row, later pair, waiting on accumulator
  typedef enum logic [1:0] {
    starter_state      = 2'd0,
    input_vector_state = 2'd1,
    input_scalar_state = 2'd2,
    ender_state        = 2'd3
  } vector_state_t;

  //////////////////////////////
  // Accumulator
  //////////////////////////////

  // Product in flight, then one cycle of modular add
  typedef enum logic [1:0] {
    idle_state       = 2'd0,
    multiply_state   = 2'd1,
    accumulate_state = 2'd2
  } scalar_state_t;

  //////////////////////////////
  // Multiplier
  //////////////////////////////

  typedef enum logic {
    mult_idle_state = 1'b0,
    mult_run_state  = 1'b1
  } multiplier_state_t;

endpackage

`default_nettype wire

// ==== logic/ntm_modular_multiplier.sv ====
// Iterative shift-and-add multiplier, reduced modulo MODULO_IN after every bit
`default_nettype none

`include "ntm_convolution_cfg.svh"

module ntm_modular_multiplier
  import ntm_convolution_pkg::*;
#(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  wire logic                 CLK,
  input  wire logic                 RST,
  input  wire logic                 START,
  input  wire logic [DATA_SIZE-1:0] MODULO_IN,
  input  wire logic [DATA_SIZE-1:0] DATA_A_IN,
  input  wire logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic                      READY,
  output logic      [DATA_SIZE-1:0] DATA_OUT
);

  localparam int COUNT_SIZE = $clog2(DATA_SIZE);
  localparam logic [COUNT_SIZE-1:0] COUNT_LAST = COUNT_SIZE'(DATA_SIZE - 1);

  multiplier_state_t multiplier_ctrl_fsm_int;
  logic [COUNT_SIZE-1:0] bit_count;

  // Operands held for the whole run; B shifts out MSB first
  logic [DATA_SIZE-1:0] modulo_int;
  logic [DATA_SIZE-1:0] data_a_int;
  logic [DATA_SIZE-1:0] data_b_int;
  logic [DATA_SIZE-1:0] product_int;

  // One extra bit, since every intermediate stays below 2*MODULO_IN
  logic [DATA_SIZE:0] modulo_ext;
  logic [DATA_SIZE:0] double_int;
  logic [DATA_SIZE:0] double_mod_int;
  logic [DATA_SIZE:0] sum_int;
  logic [DATA_SIZE:0] sum_mod_int;

  //////////////////////////////
  // Datapath step
  //////////////////////////////

  assign modulo_ext = {1'b0, modulo_int};

  // 2*p, then fold back under the modulus
  assign double_int     = {product_int, 1'b0};
  assign double_mod_int = (double_int >= modulo_ext) ? double_int - modulo_ext : double_int;

  // Add A when current bit of B is set
  assign sum_int = data_b_int[DATA_SIZE-1] ? double_mod_int + {1'b0, data_a_int}
                                           : double_mod_int;
  assign sum_mod_int = (sum_int >= modulo_ext) ? sum_int - modulo_ext : sum_int;

  always_ff @(posedge CLK) begin
    if (multiplier_ctrl_fsm_int == mult_idle_state && START) begin
      modulo_int  <= MODULO_IN;
      data_a_int  <= DATA_A_IN;
      data_b_int  <= DATA_B_IN;
      product_int <= '0;
    end else if (multiplier_ctrl_fsm_int == mult_run_state) begin
      data_b_int  <= data_b_int << 1;
      product_int <= sum_mod_int[DATA_SIZE-1:0];
    end
  end

  // Product holds after READY until the next START
  assign DATA_OUT = product_int;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      multiplier_ctrl_fsm_int <= mult_idle_state;
      bit_count <= '0;
      READY <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (multiplier_ctrl_fsm_int)
        mult_idle_state: begin
          if (START) begin
            bit_count <= COUNT_LAST;
            multiplier_ctrl_fsm_int <= mult_run_state;
          end
        end
        mult_run_state: begin
          bit_count <= bit_count - 1'b1;
          // Bit 0 processed on this edge
          if (bit_count == '0) begin
            READY <= 1'b1;
            multiplier_ctrl_fsm_int <= mult_idle_state;
          end
        end
        default: multiplier_ctrl_fsm_int <= mult_idle_state;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/ntm_scalar_convolution_function.sv ====
// Row accumulator: sums modular products of successive operand pairs
`default_nettype none

`include "ntm_convolution_cfg.svh"

module ntm_scalar_convolution_function
  import ntm_convolution_pkg::*;
#(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  wire logic                 CLK,
  input  wire logic                 RST,
  input  wire logic                 START,
  input  wire logic                 DATA_IN_ENABLE,
  input  wire logic [DATA_SIZE-1:0] MODULO_IN,
  input  wire logic [DATA_SIZE-1:0] DATA_A_IN,
  input  wire logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic                      READY,
  output logic      [DATA_SIZE-1:0] DATA_OUT
);

  scalar_state_t scalar_ctrl_fsm_int;

  // Multiplier handshake
  logic                 start_multiplier;
  logic                 ready_multiplier;
  logic [DATA_SIZE-1:0] data_out_multiplier;

  // Running row sum, always below MODULO_IN
  logic [DATA_SIZE-1:0] sum_int;
  logic [DATA_SIZE:0]   modulo_ext;
  logic [DATA_SIZE:0]   acc_int;
  logic [DATA_SIZE:0]   acc_mod_int;

  //////////////////////////////
  // Multiplier
  //////////////////////////////

  // Launched in the same cycle as the request; operands stay put until READY
  assign start_multiplier = DATA_IN_ENABLE && (scalar_ctrl_fsm_int == idle_state);

  ntm_modular_multiplier #(
    .DATA_SIZE(DATA_SIZE)
  ) u_modular_multiplier (
    .CLK      (CLK),
    .RST      (RST),
    .START    (start_multiplier),
    .MODULO_IN(MODULO_IN),
    .DATA_A_IN(DATA_A_IN),
    .DATA_B_IN(DATA_B_IN),
    .READY    (ready_multiplier),
    .DATA_OUT (data_out_multiplier)
  );

  //////////////////////////////
  // Modular add
  //////////////////////////////

  assign modulo_ext  = {1'b0, MODULO_IN};
  assign acc_int     = {1'b0, sum_int} + {1'b0, data_out_multiplier};
  assign acc_mod_int = (acc_int >= modulo_ext) ? acc_int - modulo_ext : acc_int;

  // First pair of a row starts from zero
  always_ff @(posedge CLK) begin
    if (scalar_ctrl_fsm_int == idle_state && START) begin
      sum_int <= '0;
    end else if (scalar_ctrl_fsm_int == accumulate_state) begin
      sum_int <= acc_mod_int[DATA_SIZE-1:0];
    end
  end

  // Updated on the same edge that raises READY
  assign DATA_OUT = sum_int;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      scalar_ctrl_fsm_int <= idle_state;
      READY <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (scalar_ctrl_fsm_int)
        idle_state: begin
          if (DATA_IN_ENABLE) begin
            scalar_ctrl_fsm_int <= multiply_state;
          end
        end
        multiply_state: begin
          // Product stays on the multiplier output
          if (ready_multiplier) begin
            scalar_ctrl_fsm_int <= accumulate_state;
          end
        end
        accumulate_state: begin
          READY <= 1'b1;
          scalar_ctrl_fsm_int <= idle_state;
        end
        default: scalar_ctrl_fsm_int <= idle_state;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/ntm_vector_convolution_function.sv ====
// Row and pair sequencer: collects host operands, drives the accumulator, raises strobes
`default_nettype none

`include "ntm_convolution_cfg.svh"

module ntm_vector_convolution_function
  import ntm_convolution_pkg::*;
#(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  wire logic                 CLK,
  input  wire logic                 RST,
  input  wire logic                 START,
  input  wire logic                 DATA_A_IN_VECTOR_ENABLE,
  input  wire logic                 DATA_A_IN_SCALAR_ENABLE,
  input  wire logic                 DATA_B_IN_VECTOR_ENABLE,
  input  wire logic                 DATA_B_IN_SCALAR_ENABLE,
  input  wire logic [DATA_SIZE-1:0] MODULO_IN,
  input  wire logic [DATA_SIZE-1:0] SIZE_IN,
  input  wire logic [DATA_SIZE-1:0] LENGTH_IN,
  input  wire logic [DATA_SIZE-1:0] DATA_A_IN,
  input  wire logic [DATA_SIZE-1:0] DATA_B_IN,
  input  wire logic                 ready_scalar_convolution,
  input  wire logic [DATA_SIZE-1:0] data_out_scalar_convolution,
  output logic                      READY,
  output logic                      DATA_OUT_VECTOR_ENABLE,
  output logic                      DATA_OUT_SCALAR_ENABLE,
  output logic      [DATA_SIZE-1:0] DATA_OUT,
  output logic                      start_scalar_convolution,
  output logic                      data_in_enable_scalar_convolution,
  output logic      [DATA_SIZE-1:0] modulo_scalar_convolution,
  output logic      [DATA_SIZE-1:0] data_a_scalar_convolution,
  output logic      [DATA_SIZE-1:0] data_b_scalar_convolution
);

  vector_state_t convolution_ctrl_fsm_int;

  // Run configuration, sampled on START
  logic [DATA_SIZE-1:0] size_int;
  logic [DATA_SIZE-1:0] length_int;

  // Row index i and pair index j
  logic [DATA_SIZE-1:0] index_vector_loop;
  logic [DATA_SIZE-1:0] index_scalar_loop;

  // Operand arrival, A and B may come in separate cycles
  logic data_a_strobe;
  logic data_b_strobe;
  logic data_a_flag;
  logic data_b_flag;
  logic data_a_have;
  logic data_b_have;

  logic last_pair;
  logic last_row;

  //////////////////////////////
  // Operand capture
  //////////////////////////////

  // Vector enables only for the first pair, scalar enables for the rest
  assign data_a_strobe =
    (convolution_ctrl_fsm_int == input_vector_state) ? DATA_A_IN_VECTOR_ENABLE :
    (convolution_ctrl_fsm_int == input_scalar_state) ? DATA_A_IN_SCALAR_ENABLE : 1'b0;
  assign data_b_strobe =
    (convolution_ctrl_fsm_int == input_vector_state) ? DATA_B_IN_VECTOR_ENABLE :
    (convolution_ctrl_fsm_int == input_scalar_state) ? DATA_B_IN_SCALAR_ENABLE : 1'b0;

  assign data_a_have = data_a_flag | data_a_strobe;
  assign data_b_have = data_b_flag | data_b_strobe;

  always_ff @(posedge CLK) begin
    if (convolution_ctrl_fsm_int == starter_state && START) begin
      size_int <= SIZE_IN;
      length_int <= LENGTH_IN;
      modulo_scalar_convolution <= MODULO_IN;
    end
    if (data_a_strobe) begin
      data_a_scalar_convolution <= DATA_A_IN;
    end
    if (data_b_strobe) begin
      data_b_scalar_convolution <= DATA_B_IN;
    end
  end

  assign last_pair = (index_scalar_loop == length_int - 1'b1);
  assign last_row  = (index_vector_loop == size_int - 1'b1);

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      convolution_ctrl_fsm_int <= starter_state;
      index_vector_loop <= '0;
      index_scalar_loop <= '0;
      data_a_flag <= 1'b0;
      data_b_flag <= 1'b0;
      start_scalar_convolution <= 1'b0;
      data_in_enable_scalar_convolution <= 1'b0;
      READY <= 1'b0;
      DATA_OUT_VECTOR_ENABLE <= 1'b0;
      DATA_OUT_SCALAR_ENABLE <= 1'b0;
      DATA_OUT <= '0;
    end else begin
      // All strobes are single-cycle
      start_scalar_convolution <= 1'b0;
      data_in_enable_scalar_convolution <= 1'b0;
      READY <= 1'b0;
      DATA_OUT_VECTOR_ENABLE <= 1'b0;
      DATA_OUT_SCALAR_ENABLE <= 1'b0;
      case (convolution_ctrl_fsm_int)
        starter_state: begin
          if (START) begin
            index_vector_loop <= '0;
            index_scalar_loop <= '0;
            data_a_flag <= 1'b0;
            data_b_flag <= 1'b0;
            convolution_ctrl_fsm_int <= input_vector_state;
          end
        end
        input_vector_state, input_scalar_state: begin
          data_a_flag <= data_a_have;
          data_b_flag <= data_b_have;
          // Both operands in, hand the pair over
          if (data_a_have && data_b_have) begin
            data_a_flag <= 1'b0;
            data_b_flag <= 1'b0;
            data_in_enable_scalar_convolution <= 1'b1;
            // Row start clears the running sum
            start_scalar_convolution <= (convolution_ctrl_fsm_int == input_vector_state);
            convolution_ctrl_fsm_int <= ender_state;
          end
        end
        ender_state: begin
          if (ready_scalar_convolution) begin
            DATA_OUT <= data_out_scalar_convolution;
            DATA_OUT_SCALAR_ENABLE <= 1'b1;
            if (last_pair) begin
              // Row complete, DATA_OUT is y_i
              DATA_OUT_VECTOR_ENABLE <= 1'b1;
              index_scalar_loop <= '0;
              if (last_row) begin
                READY <= 1'b1;
                convolution_ctrl_fsm_int <= starter_state;
              end else begin
                index_vector_loop <= index_vector_loop + 1'b1;
                convolution_ctrl_fsm_int <= input_vector_state;
              end
            end else begin
              index_scalar_loop <= index_scalar_loop + 1'b1;
              convolution_ctrl_fsm_int <= input_scalar_state;
            end
          end
        end
        default: convolution_ctrl_fsm_int <= starter_state;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/ntm_convolution_top.sv ====
// Convolution engine top: row sequencer feeding the modular accumulator
`default_nettype none

`include "ntm_convolution_cfg.svh"

module ntm_convolution_top #(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  wire logic                 CLK,
  input  wire logic                 RST,
  input  wire logic                 START,
  input  wire logic                 DATA_A_IN_VECTOR_ENABLE,
  input  wire logic                 DATA_A_IN_SCALAR_ENABLE,
  input  wire logic                 DATA_B_IN_VECTOR_ENABLE,
  input  wire logic                 DATA_B_IN_SCALAR_ENABLE,
  input  wire logic [DATA_SIZE-1:0] MODULO_IN,
  input  wire logic [DATA_SIZE-1:0] SIZE_IN,
  input  wire logic [DATA_SIZE-1:0] LENGTH_IN,
  input  wire logic [DATA_SIZE-1:0] DATA_A_IN,
  input  wire logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic                      READY,
  output logic                      DATA_OUT_VECTOR_ENABLE,
  output logic                      DATA_OUT_SCALAR_ENABLE,
  output logic      [DATA_SIZE-1:0] DATA_OUT
);

  //////////////////////////////
  // Sequencer to accumulator
  //////////////////////////////

  logic                 start_scalar_convolution;
  logic                 data_in_enable_scalar_convolution;
  logic                 ready_scalar_convolution;
  logic [DATA_SIZE-1:0] modulo_scalar_convolution;
  logic [DATA_SIZE-1:0] data_a_scalar_convolution;
  logic [DATA_SIZE-1:0] data_b_scalar_convolution;
  logic [DATA_SIZE-1:0] data_out_scalar_convolution;

  ntm_vector_convolution_function #(
    .DATA_SIZE(DATA_SIZE)
  ) u_vector_convolution (
    .CLK                              (CLK),
    .RST                              (RST),
    .START                            (START),
    .DATA_A_IN_VECTOR_ENABLE          (DATA_A_IN_VECTOR_ENABLE),
    .DATA_A_IN_SCALAR_ENABLE          (DATA_A_IN_SCALAR_ENABLE),
    .DATA_B_IN_VECTOR_ENABLE          (DATA_B_IN_VECTOR_ENABLE),
    .DATA_B_IN_SCALAR_ENABLE          (DATA_B_IN_SCALAR_ENABLE),
    .MODULO_IN                        (MODULO_IN),
    .SIZE_IN                          (SIZE_IN),
    .LENGTH_IN                        (LENGTH_IN),
    .DATA_A_IN                        (DATA_A_IN),
    .DATA_B_IN                        (DATA_B_IN),
    .ready_scalar_convolution         (ready_scalar_convolution),
    .data_out_scalar_convolution      (data_out_scalar_convolution),
    .READY                            (READY),
    .DATA_OUT_VECTOR_ENABLE           (DATA_OUT_VECTOR_ENABLE),
    .DATA_OUT_SCALAR_ENABLE           (DATA_OUT_SCALAR_ENABLE),
    .DATA_OUT                         (DATA_OUT),
    .start_scalar_convolution         (start_scalar_convolution),
    .data_in_enable_scalar_convolution(data_in_enable_scalar_convolution),
    .modulo_scalar_convolution        (modulo_scalar_convolution),
    .data_a_scalar_convolution        (data_a_scalar_convolution),
    .data_b_scalar_convolution        (data_b_scalar_convolution)
  );

  // Holds the running sum of the current row
  ntm_scalar_convolution_function #(
    .DATA_SIZE(DATA_SIZE)
  ) u_scalar_convolution (
    .CLK           (CLK),
    .RST           (RST),
    .START         (start_scalar_convolution),
    .DATA_IN_ENABLE(data_in_enable_scalar_convolution),
    .MODULO_IN     (modulo_scalar_convolution),
    .DATA_A_IN     (data_a_scalar_convolution),
    .DATA_B_IN     (data_b_scalar_convolution),
    .READY         (ready_scalar_convolution),
    .DATA_OUT      (data_out_scalar_convolution)
  );

endmodule

`default_nettype wire

// ==== tb/ntm_convolution_chk.sv ====
// Convolution engine checker: concurrent assertions on the top-level output strobes
`default_nettype none

`include "ntm_convolution_cfg.svh"

module ntm_convolution_chk #(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input wire logic                 CLK,
  input wire logic                 RST,
  input wire logic                 START,
  input wire logic [DATA_SIZE-1:0] MODULO_IN,
  input wire logic                 READY,
  input wire logic                 DATA_OUT_VECTOR_ENABLE,
  input wire logic                 DATA_OUT_SCALAR_ENABLE,
  input wire logic [DATA_SIZE-1:0] DATA_OUT
);

  // Run in progress and the modulus taken at its START
  logic                 busy;
  logic [DATA_SIZE-1:0] modulo_seen;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy <= 1'b0;
      modulo_seen <= '0;
    end else if (START && !busy) begin
      busy <= 1'b1;
      modulo_seen <= MODULO_IN;
    end else if (READY) begin
      busy <= 1'b0;
    end
  end

  //////////////////////////////
  // Strobe relations
  //////////////////////////////

  // End of run always carries a pair result
  a_ready_with_scalar: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_SCALAR_ENABLE) else $error("READY without DATA_OUT_SCALAR_ENABLE");

  // Row result is also the last partial sum
  a_vector_with_scalar: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_VECTOR_ENABLE |-> DATA_OUT_SCALAR_ENABLE)
    else $error("DATA_OUT_VECTOR_ENABLE without DATA_OUT_SCALAR_ENABLE");

  // Every output value is already reduced
  a_data_reduced: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_SCALAR_ENABLE |-> (DATA_OUT < modulo_seen)) else $error("DATA_OUT not reduced");

  //////////////////////////////
  // Single-cycle pulses
  //////////////////////////////

  a_ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    READY |=> !READY) else $error("READY longer than one cycle");

  a_vector_pulse: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_VECTOR_ENABLE |=> !DATA_OUT_VECTOR_ENABLE)
    else $error("DATA_OUT_VECTOR_ENABLE longer than one cycle");

  a_scalar_pulse: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_SCALAR_ENABLE |=> !DATA_OUT_SCALAR_ENABLE)
    else $error("DATA_OUT_SCALAR_ENABLE longer than one cycle");

endmodule

bind ntm_convolution_top ntm_convolution_chk #(
  .DATA_SIZE(DATA_SIZE)
) u_ntm_convolution_chk (
  .CLK                   (CLK),
  .RST                   (RST),
  .START                 (START),
  .MODULO_IN             (MODULO_IN),
  .READY                 (READY),
  .DATA_OUT_VECTOR_ENABLE(DATA_OUT_VECTOR_ENABLE),
  .DATA_OUT_SCALAR_ENABLE(DATA_OUT_SCALAR_ENABLE),
  .DATA_OUT              (DATA_OUT)
);

`default_nettype wire

// ==== tb/ntm_convolution_tb.sv ====
// Convolution engine testbench driving random runs against a modular dot-product model
`default_nettype none

`include "ntm_convolution_cfg.svh"

module ntm_convolution_tb;

  localparam int DATA_SIZE = `NTM_DATA_SIZE;
  localparam int WAIT_LIMIT = 200;
  localparam logic [31:0] SEED = 32'h1ace_6731;

  logic                 CLK = 1'b0;
  logic                 RST;
  logic                 START;
  logic                 DATA_A_IN_VECTOR_ENABLE;
  logic                 DATA_A_IN_SCALAR_ENABLE;
  logic                 DATA_B_IN_VECTOR_ENABLE;
  logic                 DATA_B_IN_SCALAR_ENABLE;
  logic [DATA_SIZE-1:0] MODULO_IN;
  logic [DATA_SIZE-1:0] SIZE_IN;
  logic [DATA_SIZE-1:0] LENGTH_IN;
  logic [DATA_SIZE-1:0] DATA_A_IN;
  logic [DATA_SIZE-1:0] DATA_B_IN;
  logic                 READY;
  logic                 DATA_OUT_VECTOR_ENABLE;
  logic                 DATA_OUT_SCALAR_ENABLE;
  logic [DATA_SIZE-1:0] DATA_OUT;

  logic [31:0] lcg_state;

  // Expected strobe per pair as {READY, DATA_OUT_VECTOR_ENABLE, DATA_OUT}
  logic [DATA_SIZE+1:0] expect_q[$];
  int vector_count = 0;
  int ready_count = 0;

  always #4 CLK = ~CLK;

  ntm_convolution_top u_ntm_convolution_top (
    .CLK                    (CLK),
    .RST                    (RST),
    .START                  (START),
    .DATA_A_IN_VECTOR_ENABLE(DATA_A_IN_VECTOR_ENABLE),
    .DATA_A_IN_SCALAR_ENABLE(DATA_A_IN_SCALAR_ENABLE),
    .DATA_B_IN_VECTOR_ENABLE(DATA_B_IN_VECTOR_ENABLE),
    .DATA_B_IN_SCALAR_ENABLE(DATA_B_IN_SCALAR_ENABLE),
    .MODULO_IN              (MODULO_IN),
    .SIZE_IN                (SIZE_IN),
    .LENGTH_IN              (LENGTH_IN),
    .DATA_A_IN              (DATA_A_IN),
    .DATA_B_IN              (DATA_B_IN),
    .READY                  (READY),
    .DATA_OUT_VECTOR_ENABLE (DATA_OUT_VECTOR_ENABLE),
    .DATA_OUT_SCALAR_ENABLE (DATA_OUT_SCALAR_ENABLE),
    .DATA_OUT               (DATA_OUT)
  );

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic stop_on_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_error(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    stop_on_failure();
  endtask

  task automatic check_value(input logic [DATA_SIZE-1:0] actual,
                             input logic [DATA_SIZE-1:0] expected, input string what);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s got %0h expected %0h", $time, what, actual, expected);
      stop_on_failure();
    end
  endtask

  //////////////////////////////
  // Random numbers and model
  //////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper halves of two steps since the low LCG bits are weak
  task automatic draw_below(input logic [31:0] bound, output logic [31:0] value);
    logic [31:0] first_half;
    lcg_state = lcg_step(lcg_state);
    first_half = lcg_state;
    lcg_state = lcg_step(lcg_state);
    value = {first_half[31:16], lcg_state[31:16]} % bound;
  endtask

  // Row sum after one more pair with 64 bits holding any 32-bit product
  function automatic logic [63:0] next_partial_sum(input logic [63:0] sum, input logic [63:0] a,
                                                   input logic [63:0] b, input logic [63:0] m);
    logic [63:0] product;
    product = (a * b) % m;
    return (sum + product) % m;
  endfunction

  //////////////////////////////
  // Host side
  //////////////////////////////

  task automatic set_enables(input logic vector_kind, input logic a_en, input logic b_en);
    DATA_A_IN_VECTOR_ENABLE = vector_kind & a_en;
    DATA_B_IN_VECTOR_ENABLE = vector_kind & b_en;
    DATA_A_IN_SCALAR_ENABLE = !vector_kind & a_en;
    DATA_B_IN_SCALAR_ENABLE = !vector_kind & b_en;
  endtask

  task automatic check_idle_outputs();
    check_value(DATA_SIZE'(READY), '0, "READY in reset");
    check_value(DATA_SIZE'(DATA_OUT_VECTOR_ENABLE), '0, "DATA_OUT_VECTOR_ENABLE in reset");
    check_value(DATA_SIZE'(DATA_OUT_SCALAR_ENABLE), '0, "DATA_OUT_SCALAR_ENABLE in reset");
    check_value(DATA_OUT, '0, "DATA_OUT in reset");
  endtask

  // Noisy pairs add idle gaps, wrong-kind enables, split A and B and junk in ender_state
  task automatic drive_pair(input logic [31:0] a, input logic [31:0] b, input logic first,
                            input logic noisy);
    logic [31:0] idle;
    logic [31:0] order;
    logic [31:0] gap;
    logic [31:0] junk;
    order = '0;
    gap = 32'd1;
    junk = '0;
    if (noisy) begin
      draw_below(32'd3, idle);
      draw_below(32'd3, order);
      draw_below(32'd3, gap);
      gap = gap + 32'd1;
      draw_below(32'hffff_ffff, junk);
      repeat (idle + 32'd1) @(posedge CLK);
      #1;
      DATA_A_IN = junk;
      DATA_B_IN = ~junk;
      set_enables(!first, 1'b1, 1'b1);
    end
    @(posedge CLK);
    #1;
    if (order == 32'd0) begin
      DATA_A_IN = a;
      DATA_B_IN = b;
      set_enables(first, 1'b1, 1'b1);
    end else begin
      // One operand now and the other after the gap
      DATA_A_IN = a;
      DATA_B_IN = b;
      set_enables(first, order == 32'd1, order == 32'd2);
      @(posedge CLK);
      #1;
      set_enables(first, 1'b0, 1'b0);
      if (order == 32'd1) DATA_A_IN = ~a;
      else DATA_B_IN = ~b;
      repeat (gap) @(posedge CLK);
      #1;
      set_enables(first, order == 32'd2, order == 32'd1);
    end
    @(posedge CLK);
    #1;
    set_enables(first, 1'b0, 1'b0);
    if (noisy) begin
      DATA_A_IN = junk;
      DATA_B_IN = junk ^ 32'h0f0f_0f0f;
      set_enables(first, 1'b1, 1'b1);
      @(posedge CLK);
      #1;
      set_enables(first, 1'b0, 1'b0);
    end
  endtask

  task automatic wait_for_scalar_strobe();
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (!DATA_OUT_SCALAR_ENABLE) begin
      if (cycles == WAIT_LIMIT) begin
        report_error("no DATA_OUT_SCALAR_ENABLE within the wait limit");
      end else begin
        cycles++;
        @(negedge CLK);
      end
    end
  endtask

  task automatic run_convolution(input logic [31:0] size, input logic [31:0] length,
                                 input logic [31:0] modulo, input logic near_top,
                                 input logic noisy);
    logic [63:0] sum;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] junk;
    logic        last_pair;
    logic        last_row;
    int          vector_before;
    int          ready_before;
    vector_before = vector_count;
    ready_before = ready_count;
    @(posedge CLK);
    #1;
    SIZE_IN = size;
    LENGTH_IN = length;
    MODULO_IN = modulo;
    START = 1'b1;
    @(posedge CLK);
    #1;
    START = 1'b0;
    // Configuration is latched so scramble it
    if (noisy) begin
      draw_below(32'hffff_ffff, junk);
      SIZE_IN = junk;
      LENGTH_IN = ~junk;
      MODULO_IN = junk ^ 32'h5a5a_5a5a;
    end
    for (int i = 0; i < size; i++) begin
      sum = '0;
      for (int j = 0; j < length; j++) begin
        draw_below(near_top ? 32'd4 : modulo, a);
        draw_below(near_top ? 32'd4 : modulo, b);
        if (near_top) begin
          a = modulo - 32'd1 - a;
          b = modulo - 32'd1 - b;
        end
        sum = next_partial_sum(sum, 64'(a), 64'(b), 64'(modulo));
        last_pair = (j == length - 1);
        last_row = (i == size - 1);
        expect_q.push_back({last_row & last_pair, last_pair, sum[DATA_SIZE-1:0]});
        drive_pair(a, b, j == 0, noisy);
        wait_for_scalar_strobe();
      end
    end
    // Let the comparing process see the final strobe
    @(posedge CLK);
    check_value(DATA_SIZE'(vector_count - vector_before), size, "row results per run");
    check_value(DATA_SIZE'(ready_count - ready_before), 32'd1, "READY pulses per run");
    check_value(DATA_SIZE'(expect_q.size()), '0, "pairs without a result");
  endtask

  //////////////////////////////
  // Compare
  //////////////////////////////

  always @(negedge CLK) begin
    logic [DATA_SIZE+1:0] expected;
    if (!RST) begin
      if (DATA_OUT_SCALAR_ENABLE) begin
        if (expect_q.size() == 0) begin
          report_error("DATA_OUT_SCALAR_ENABLE pulsed with no pair outstanding");
        end else begin
          expected = expect_q.pop_front();
          check_value(DATA_OUT, expected[DATA_SIZE-1:0], "DATA_OUT");
          check_value(DATA_SIZE'(DATA_OUT_VECTOR_ENABLE), DATA_SIZE'(expected[DATA_SIZE]),
                      "DATA_OUT_VECTOR_ENABLE");
          check_value(DATA_SIZE'(READY), DATA_SIZE'(expected[DATA_SIZE+1]), "READY");
        end
      end else if (DATA_OUT_VECTOR_ENABLE || READY) begin
        report_error("row or run strobe without DATA_OUT_SCALAR_ENABLE");
      end
      if (DATA_OUT_VECTOR_ENABLE) vector_count++;
      if (READY) ready_count++;
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    logic [31:0] size;
    logic [31:0] length;
    logic [31:0] modulo;
    logic [31:0] range;
    lcg_state = SEED;
    RST = 1'b1;
    START = 1'b0;
    set_enables(1'b0, 1'b0, 1'b0);
    MODULO_IN = '0;
    SIZE_IN = '0;
    LENGTH_IN = '0;
    DATA_A_IN = '0;
    DATA_B_IN = '0;
    repeat (4) begin
      @(negedge CLK);
      check_idle_outputs();
    end
    @(posedge CLK);
    #1;
    RST = 1'b0;
    repeat (2) begin
      @(negedge CLK);
      check_idle_outputs();
    end

    // One pair with all three strobes together
    run_convolution(32'd1, 32'd1, 32'd13, 1'b0, 1'b0);

    // Random shapes with small, medium and full-width moduli
    repeat (24) begin
      draw_below(32'd4, size);
      draw_below(32'd5, length);
      draw_below(32'd3, range);
      draw_below(range == 0 ? 32'd14 : range == 1 ? 32'd65534 : 32'hffff_fffd, modulo);
      run_convolution(size + 32'd1, length + 32'd1, modulo + 32'd2, 1'b0, range[0]);
    end

    // Wrap near 2^32
    run_convolution(32'd2, 32'd3, 32'hffff_fffb, 1'b1, 1'b0);
    run_convolution(32'd3, 32'd2, 32'hffff_ffff, 1'b1, 1'b0);
    run_convolution(32'd2, 32'd4, 32'hffff_fffb, 1'b1, 1'b1);

    // Back-to-back noisy runs
    repeat (8) begin
      draw_below(32'd4, size);
      draw_below(32'd5, length);
      draw_below(32'h00ff_fffe, modulo);
      run_convolution(size + 32'd1, length + 32'd1, modulo + 32'd2, 1'b0, 1'b1);
    end

    @(posedge CLK);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
logic/ntm_convolution_pkg.sv
logic/ntm_modular_multiplier.sv
logic/ntm_scalar_convolution_function.sv
logic/ntm_vector_convolution_function.sv
logic/ntm_convolution_top.sv
tb/ntm_convolution_chk.sv
tb/ntm_convolution_tb.sv

// ==== Makefile ====
TOP := ntm_convolution_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
